/* rtl/music_format_pkg.sv */
`default_nettype none

package music_format_pkg;

    // Address layout. The song select sits above the note index.
    localparam int song_sel_width  = 2;
    localparam int note_addr_width = 4;  // 16 words per song.
    localparam int rom_addr_width  = song_sel_width + note_addr_width;
    localparam int rom_depth       = 2 ** rom_addr_width;
    localparam int rom_word_width  = 16;

    // Song image that fills the ROM.
    localparam string song_file = "rtl/song_data.hex";

    // Fields of a ROM word.
    localparam int effect_bit     = 15;  // Set for an effect word.
    localparam int note_msb       = 14;
    localparam int note_lsb       = 9;
    localparam int note_width     = note_msb - note_lsb + 1;
    localparam int duration_msb   = 8;
    localparam int duration_lsb   = 3;
    localparam int duration_width = duration_msb - duration_lsb + 1;  // In beats.
    localparam int param_msb      = 2;
    localparam int param_lsb      = 0;
    localparam int param_width    = param_msb - param_lsb + 1;

    typedef enum logic [2:0] {
        paused         = 3'b000,
        wait_done      = 3'b001,
        change_address = 3'b010,
        retrieve_note  = 3'b011,
        new_note_ready = 3'b100
    } reader_state_t;

endpackage

`default_nettype wire

/* rtl/music_timing_pkg.sv */
`default_nettype none

package music_timing_pkg;

    // A beat is kept very short so that whole songs fit in a short simulation.
    // A real player would set this from the clock rate and the tempo.
    localparam int beat_cycles = 4;

    // Width of the divider that counts clock cycles within one beat.
    localparam int beat_count_width = (beat_cycles > 1) ? $clog2(beat_cycles) : 1;

    // Cycles from a ROM address to its data word.
    // The reader FSM spends exactly one state waiting for the word,
    // so this stays at one.
    localparam int rom_latency = 1;

endpackage

`default_nettype wire

/* rtl/song_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module song_rom (
    input  wire logic                                      clk,
    input  wire logic [music_format_pkg::rom_addr_width-1:0] addr,
    output logic      [music_format_pkg::rom_word_width-1:0] dout
);
    import music_format_pkg::*;
    import music_timing_pkg::*;

    logic [rom_word_width-1:0] mem [rom_depth];
    logic [rom_word_width-1:0] pipe [rom_latency];  // Read data stages.

    initial $readmemh(song_file, mem);

    always_ff @(posedge clk) begin
        pipe[0] <= mem[addr];
        for (int i = 1; i < rom_latency; i++) begin
            pipe[i] <= pipe[i-1];
        end
    end

    assign dout = pipe[rom_latency-1];

endmodule

`default_nettype wire

/* rtl/player_config.sv */
`timescale 1ns/1ps
`default_nettype none

module player_config (
    input  wire logic                                      clk,
    input  wire logic                                      reset,
    input  wire logic                                      cfg_write,
    input  wire logic                                      cfg_play,
    input  wire logic [music_format_pkg::song_sel_width-1:0] cfg_song,
    input  wire logic                                      cfg_ff,
    input  wire logic                                      cfg_rewind,
    input  wire logic                                      song_done,
    output logic                                           play,
    output logic      [music_format_pkg::song_sel_width-1:0] song,
    output logic                                           ff_switch,
    output logic                                           rewind_switch
);

    // All four registers load together on the write strobe.
    // The reader stops on its own at the end of a song, so play is also
    // cleared here one cycle after song_done.
    always_ff @(posedge clk) begin
        if (reset) begin
            play          <= 1'b0;
            song          <= '0;
            ff_switch     <= 1'b0;
            rewind_switch <= 1'b0;
        end else if (cfg_write) begin  // A write wins over song_done.
            play          <= cfg_play;
            song          <= cfg_song;
            ff_switch     <= cfg_ff;
            rewind_switch <= cfg_rewind;
        end else if (song_done) begin
            play <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rtl/song_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module song_reader (
    input  wire logic                                        clk,
    input  wire logic                                        reset,
    input  wire logic                                        play,
    input  wire logic [music_format_pkg::song_sel_width-1:0] song,
    input  wire logic                                        ff_switch,
    input  wire logic                                        rewind_switch,
    input  wire logic                                        note_done,
    input  wire logic                                        activate_done,
    input  wire logic [music_format_pkg::rom_word_width-1:0] rom_word,
    output logic      [music_format_pkg::rom_addr_width-1:0] rom_addr,
    output logic                                             new_note,
    output logic      [music_format_pkg::note_width-1:0]     note,
    output logic      [music_format_pkg::duration_width-1:0] duration,
    output logic                                             activate,
    output logic      [music_format_pkg::param_width-1:0]    parameters,
    output logic                                             song_done
);
    import music_format_pkg::*;

    reader_state_t state, next_state;

    logic [note_addr_width-1:0] note_addr;
    logic [note_addr_width-1:0] next_addr;
    logic                       carry;        // Forward step ran past the last word.
    logic [duration_width-1:0]  stored_duration;
    logic                       word_done;    // The current note or effect has ended.

    // The ROM sees the address of the current word in every state,
    // so rom_word stays valid for as long as the reader waits on it.
    assign rom_addr = {song, note_addr};

    // Address step, taken only in change_address.
    always_comb begin
        next_addr = note_addr;
        carry     = 1'b0;
        if (state == change_address) begin
            if (rewind_switch) begin
                if (note_addr != '0) begin
                    next_addr = note_addr - 1'b1;  // Rewind stops at word 0, no wrap.
                end
            end else begin
                {carry, next_addr} = {1'b0, note_addr} + 1'b1;
            end
        end
    end

    assign song_done = (state == change_address) &&
                       (rewind_switch ? (note_addr == '0) : carry);

    // An effect word finishes on activate_done, a note word on note_done.
    assign word_done = rom_word[effect_bit] ? activate_done : note_done;

    always_comb begin
        case (state)
            paused:         next_state = play ? retrieve_note : paused;
            retrieve_note:  next_state = play ? new_note_ready : paused;
            new_note_ready: next_state = play ? wait_done : paused;
            wait_done: begin
                if (!play) begin
                    next_state = paused;
                end else if (word_done) begin
                    next_state = change_address;
                end else begin
                    next_state = wait_done;
                end
            end
            change_address: begin
                next_state = (play && !song_done) ? retrieve_note : paused;
            end
            default:        next_state = paused;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= paused;
            note_addr <= '0;
        end else begin
            state     <= next_state;
            note_addr <= next_addr;  // Held everywhere except change_address.
        end
    end

    // Word fields go straight out, valid while new_note is high.
    assign new_note        = (state == new_note_ready);
    assign note            = rom_word[note_msb:note_lsb];
    assign stored_duration = rom_word[duration_msb:duration_lsb];
    assign duration        = (ff_switch || rewind_switch) ? (stored_duration >> 1)
                                                          : stored_duration;
    assign activate        = rom_word[effect_bit];
    assign parameters      = rom_word[param_msb:param_lsb];

endmodule

`default_nettype wire

/* rtl/note_player.sv */
`timescale 1ns/1ps
`default_nettype none

module note_player (
    input  wire logic                                        clk,
    input  wire logic                                        reset,
    input  wire logic                                        new_note,
    input  wire logic                                        activate,
    input  wire logic [music_format_pkg::duration_width-1:0] duration,
    output logic                                             beat,
    output logic                                             note_done
);
    import music_format_pkg::*;
    import music_timing_pkg::*;

    logic [beat_count_width-1:0] beat_count;
    logic [duration_width-1:0]   beats_left;
    logic                        note_active;

    // Free-running divider. The beat pulse does not follow note starts,
    // so a note's length in cycles depends on where in the beat it began.
    always_ff @(posedge clk) begin
        if (reset) begin
            beat_count <= '0;
            beat       <= 1'b0;
        end else begin
            beat       <= (beat_count == beat_count_width'(beat_cycles - 1));
            beat_count <= (beat_count == beat_count_width'(beat_cycles - 1)) ? '0
                                                                             : beat_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            note_active <= 1'b0;
            note_done   <= 1'b0;
        end else begin
            note_done <= 1'b0;
            if (new_note) begin
                note_active <= !activate;  // An effect word cancels any leftover note.
            end else if (note_active && beat && beats_left == 1) begin
                note_active <= 1'b0;
                note_done   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_note) begin
            beats_left <= (duration == '0) ? duration_width'(1) : duration;  // At least one beat.
        end else if (note_active && beat) begin
            beats_left <= beats_left - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/effect_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module effect_unit (
    input  wire logic                                     clk,
    input  wire logic                                     reset,
    input  wire logic                                     new_note,
    input  wire logic                                     activate,
    input  wire logic [music_format_pkg::param_width-1:0] parameters,
    input  wire logic                                     beat,
    output logic                                          effect_active,
    output logic      [music_format_pkg::param_width-1:0] effect_code,
    output logic                                          activate_done
);
    import music_format_pkg::*;

    logic [param_width-1:0] beats_left;  // Beats still to run after the current one.

    always_ff @(posedge clk) begin
        if (reset) begin
            effect_active <= 1'b0;
            activate_done <= 1'b0;
        end else begin
            activate_done <= 1'b0;
            if (new_note) begin
                effect_active <= activate;  // A note word ends any stale effect.
            end else if (effect_active && beat && beats_left == '0) begin
                effect_active <= 1'b0;
                activate_done <= 1'b1;
            end
        end
    end

    // The code is held for parameters plus one beats.
    always_ff @(posedge clk) begin
        if (new_note && activate) begin
            effect_code <= parameters;
            beats_left  <= parameters;
        end else if (effect_active && beat) begin
            beats_left <= beats_left - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/music_player.sv */
`timescale 1ns/1ps
`default_nettype none

module music_player (
    input  wire logic                                        clk,
    input  wire logic                                        reset,
    input  wire logic                                        cfg_write,
    input  wire logic                                        cfg_play,
    input  wire logic [music_format_pkg::song_sel_width-1:0] cfg_song,
    input  wire logic                                        cfg_ff,
    input  wire logic                                        cfg_rewind,
    output logic      [music_format_pkg::note_width-1:0]     note,
    output logic      [music_format_pkg::duration_width-1:0] duration,
    output logic                                             new_note,
    output logic                                             effect_active,
    output logic      [music_format_pkg::param_width-1:0]    effect_code,
    output logic                                             song_done,
    output logic                                             playing
);
    import music_format_pkg::*;

    logic [song_sel_width-1:0] song;
    logic                      ff_switch;
    logic                      rewind_switch;
    logic [rom_addr_width-1:0] rom_addr;
    logic [rom_word_width-1:0] rom_word;
    logic                      activate;
    logic [param_width-1:0]    parameters;
    logic                      beat;
    logic                      note_done;
    logic                      activate_done;

    // The play register itself is the playing output.
    player_config u_config (
        .clk(clk), .reset(reset), .cfg_write(cfg_write), .cfg_play(cfg_play),
        .cfg_song(cfg_song), .cfg_ff(cfg_ff), .cfg_rewind(cfg_rewind),
        .song_done(song_done), .play(playing), .song(song),
        .ff_switch(ff_switch), .rewind_switch(rewind_switch)
    );

    song_reader u_reader (
        .clk(clk), .reset(reset), .play(playing), .song(song),
        .ff_switch(ff_switch), .rewind_switch(rewind_switch),
        .note_done(note_done), .activate_done(activate_done), .rom_word(rom_word),
        .rom_addr(rom_addr), .new_note(new_note), .note(note), .duration(duration),
        .activate(activate), .parameters(parameters), .song_done(song_done)
    );

    song_rom u_rom (.clk(clk), .addr(rom_addr), .dout(rom_word));

    note_player u_note (
        .clk(clk), .reset(reset), .new_note(new_note), .activate(activate),
        .duration(duration), .beat(beat), .note_done(note_done)
    );

    effect_unit u_effect (
        .clk(clk), .reset(reset), .new_note(new_note), .activate(activate),
        .parameters(parameters), .beat(beat), .effect_active(effect_active),
        .effect_code(effect_code), .activate_done(activate_done)
    );

endmodule

`default_nettype wire

/* verif/music_player_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module music_player_tb;
    import music_format_pkg::*;
    import music_timing_pkg::*;

    logic                      clk;
    logic                      reset;
    logic                      cfg_write;
    logic                      cfg_play;
    logic [song_sel_width-1:0] cfg_song;
    logic                      cfg_ff;
    logic                      cfg_rewind;
    logic [note_width-1:0]     note;
    logic [duration_width-1:0] duration;
    logic                      new_note;
    logic                      effect_active;
    logic [param_width-1:0]    effect_code;
    logic                      song_done;
    logic                      playing;

    logic [rom_word_width-1:0] song_image [rom_depth];  // Reference copy of the song data.

    // Reference model of the player registers and the note address.
    logic [song_sel_width-1:0]  m_song;
    logic [note_addr_width-1:0] m_addr;
    logic                       m_ff;
    logic                       m_rewind;

    integer seed = 37;
    int     value_errors = 0;
    int     timeouts = 0;
    bit     timed_out = 1'b0;  // Later waits return at once after a timeout.

    music_player DUT (
        .clk(clk), .reset(reset), .cfg_write(cfg_write), .cfg_play(cfg_play),
        .cfg_song(cfg_song), .cfg_ff(cfg_ff), .cfg_rewind(cfg_rewind),
        .note(note), .duration(duration), .new_note(new_note),
        .effect_active(effect_active), .effect_code(effect_code),
        .song_done(song_done), .playing(playing)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int pick(input int lo, input int hi);
        return lo + ($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic report_timeout(input string what);
        timeouts++;
        timed_out = 1'b1;
        $display("Timeout at t=%0t: %s did not arrive in time", $time, what);
    endtask

    // One write strobe. Returns on the next falling edge with the strobe low.
    task automatic write_cfg(input bit play_bit, input int song_sel, input bit ff, input bit rw);
        cfg_write  = 1'b1;
        cfg_play   = play_bit;
        cfg_song   = song_sel_width'(song_sel);
        cfg_ff     = ff;
        cfg_rewind = rw;
        m_song     = song_sel_width'(song_sel);
        m_ff       = ff;
        m_rewind   = rw;
        @(negedge clk);
        cfg_write = 1'b0;
    endtask

    task automatic wait_new_note(input int limit, output int cycles);
        cycles = 0;
        if (timed_out) return;
        do begin
            @(negedge clk);
            cycles++;
        end while (!new_note && cycles < limit);
        if (!new_note) report_timeout("new_note");
    endtask

    // The write itself takes one cycle, so the reader should answer two cycles later.
    task automatic start_play(input int song_sel, input bit ff, input bit rw);
        int cycles;
        write_cfg(1'b1, song_sel, ff, rw);
        wait_new_note(8, cycles);
        if (timed_out) return;
        assert (cycles + 1 == 3) else begin
            value_errors++;
            $display("[ERROR] t=%0t: new_note %0d cycles after the play write, expected 3",
                     $time, cycles + 1);
        end
    endtask

    task automatic pause_play(input int hold);
        write_cfg(1'b0, m_song, m_ff, m_rewind);
        repeat (hold) begin
            @(negedge clk);
            assert (!new_note && !playing) else begin
                value_errors++;
                $display("[ERROR] t=%0t: player still active while paused", $time);
            end
        end
    endtask

    // Checks the word on the current new_note and follows it to the next word or song end.
    task automatic run_word(output bit ended);
        logic [rom_word_width-1:0]  word;
        logic [duration_width-1:0]  exp_duration;
        logic [note_addr_width-1:0] end_addr;
        int beats;
        int cycles;
        int active_cycles;
        bit is_effect;
        ended = 1'b0;
        if (timed_out) return;
        word = song_image[{m_song, m_addr}];
        is_effect = word[effect_bit];
        exp_duration = word[duration_msb:duration_lsb];
        if (m_ff || m_rewind) begin
            exp_duration = exp_duration >> 1;
        end
        assert (new_note && note == word[note_msb:note_lsb] && duration == exp_duration) else begin
            value_errors++;
            $display("[ERROR] t=%0t: song %0d word %0d gave note %0d dur %0d, expected %0d dur %0d",
                     $time, m_song, m_addr, note, duration, word[note_msb:note_lsb], exp_duration);
        end
        if (is_effect) begin
            beats = word[param_msb:param_lsb] + 1;
        end else begin
            beats = (exp_duration == 0) ? 1 : exp_duration;  // A note lasts at least one beat.
        end
        cycles = 0;
        active_cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (effect_active) begin
                active_cycles++;
                assert (effect_code == word[param_msb:param_lsb]) else begin
                    value_errors++;
                    $display("[ERROR] t=%0t: effect_code %0d, expected %0d",
                             $time, effect_code, word[param_msb:param_lsb]);
                end
            end
        end while (!new_note && !song_done && cycles < beats * beat_cycles + 8);
        if (!new_note && !song_done) begin
            report_timeout("end of the current word");
            return;
        end
        // The beat phase moves the end by up to one beat.
        assert (is_effect ? (active_cycles > (beats - 1) * beat_cycles &&
                             active_cycles <= beats * beat_cycles)
                          : active_cycles == 0) else begin
            value_errors++;
            $display("[ERROR] t=%0t: effect_active high for %0d cycles over %0d beats",
                     $time, active_cycles, beats);
        end
        if (m_rewind) begin
            end_addr = '0;
        end else begin
            end_addr = '1;
        end
        ended = song_done;
        assert ((song_done == (m_addr == end_addr)) &&
                cycles >= (beats - 1) * beat_cycles + (song_done ? 3 : 5) &&
                cycles <= beats * beat_cycles + (song_done ? 2 : 4)) else begin
            value_errors++;
            $display("[ERROR] t=%0t: word %0d ended after %0d cycles with song_done %0b",
                     $time, m_addr, cycles, song_done);
        end
        if (!m_rewind) begin
            m_addr = m_addr + 1'b1;  // Wraps to 0 at the song end.
        end else if (!song_done) begin
            m_addr = m_addr - 1'b1;
        end
    endtask

    task automatic advance(input int words);
        bit ended;
        repeat (words) begin
            run_word(ended);
            assert (!ended) else begin
                value_errors++;
                $display("[ERROR] t=%0t: song_done before the expected song end", $time);
            end
        end
    endtask

    task automatic play_through();
        bit ended;
        int words;
        ended = 1'b0;
        words = 0;
        while (!ended && !timed_out && words <= 16) begin
            run_word(ended);
            words++;
        end
        if (timed_out) return;
        @(negedge clk);
        assert (ended && !song_done && !playing) else begin
            value_errors++;
            $display("[ERROR] t=%0t: song end wrong, ended %0b song_done %0b playing %0b",
                     $time, ended, song_done, playing);
        end
    endtask

    initial begin
        int start_addr;
        reset      = 1'b1;
        cfg_write  = 1'b0;
        cfg_play   = 1'b0;
        cfg_song   = '0;
        cfg_ff     = 1'b0;
        cfg_rewind = 1'b0;
        m_song     = '0;
        m_addr     = '0;
        m_ff       = 1'b0;
        m_rewind   = 1'b0;
        $readmemh(song_file, song_image);
        repeat (5) @(negedge clk);
        reset = 1'b0;
        assert (!new_note && !song_done && !effect_active && !playing) else begin
            value_errors++;
            $display("[ERROR] t=%0t: outputs not idle after reset", $time);
        end

        // Forward playback of random songs, then one song in fast-forward.
        repeat (2) begin
            start_play(pick(0, 3), 1'b0, 1'b0);
            play_through();
        end
        start_play(pick(0, 3), 1'b1, 1'b0);
        play_through();

        // Pauses in the middle of a word resume at the same word.
        start_play(pick(0, 3), 1'b0, 1'b0);
        repeat (3) begin
            advance(pick(1, 3));
            repeat (pick(0, 1)) @(negedge clk);
            pause_play(pick(2, 10));
            start_play(m_song, 1'b0, 1'b0);
        end
        pause_play(pick(2, 6));
        write_cfg(1'b0, (m_song + pick(1, 3)) % 4, 1'b0, 1'b0);  // New song, same index.
        start_play(m_song, 1'b0, 1'b0);
        play_through();

        // Rewind from a random word down to word 0.
        start_addr = pick(2, 12);
        start_play(pick(0, 3), 1'b0, 1'b0);
        advance(start_addr);
        pause_play(pick(2, 6));
        start_play(m_song, 1'b0, 1'b1);
        play_through();
        start_play(m_song, 1'b0, 1'b0);
        advance(1);
        pause_play(2);

        $display("Checks done: %0d value errors, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* music_player.f */
rtl/music_format_pkg.sv
rtl/music_timing_pkg.sv
rtl/song_rom.sv
rtl/player_config.sv
rtl/song_reader.sv
rtl/note_player.sv
rtl/effect_unit.sv
rtl/music_player.sv
verif/music_player_tb.sv

/* Bender.yml */
package:
  name: music_player

sources:
  - files:
      - rtl/music_format_pkg.sv
      - rtl/music_timing_pkg.sv
      - rtl/song_rom.sv
      - rtl/player_config.sv
      - rtl/song_reader.sv
      - rtl/note_player.sv
      - rtl/effect_unit.sv
      - rtl/music_player.sv
  - target: simulation
    files:
      - verif/music_player_tb.sv

/* rtl/song_data.hex */
// One 16-bit word per line: bit 15 effect, 14:9 note, 8:3 duration in beats, 2:0 effect code.
// Songs 0 to 3 follow in address order, 16 words each.
2810
2c08
3010
2818
8011
2620
2810
3408
3010
2c18
8002
2810
2608
2420
3010
2820
1c10
2208
2610
1c08
8213
1818
1c10
2210
1408
8000
2210
2618
1c08
1810
1408
1c28
4010
4410
4808
4c18
8a0a
5010
5208
4c10
4808
4420
8003
4010
3e08
3a10
3610
3420
3008
3408
3610
3a08
3e18
8011
3a10
3610
3408
3010
2c08
8404
2810
3010
3410
3820
